// File: src.f
hw/join_pkg.sv
hw/two_fifo.sv
hw/operand_join.sv
hw/join_top.sv
bench/join_assertions.sv
bench/join_tb.sv

// File: Makefile
# Verilator simulation of the join stage testbench

VERILATOR ?= verilator
TOP       ?= join_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/join_tb.sv
/* LCG traffic into join_top checked against a reference model
   stops at the first mismatch or timeout */

`timescale 1ns/1ps

module join_tb;

   logic                        clk_i;
   logic                        reset_i;
   logic                        a_v_i;
   join_pkg::join_op_e          a_op_i;
   logic [join_pkg::DATA_W-1:0] a_data_i;
   logic                        a_ready_o;
   logic                        b_v_i;
   logic [join_pkg::DATA_W-1:0] b_data_i;
   logic                        b_ready_o;
   logic                        res_v_o;
   logic [join_pkg::DATA_W-1:0] res_data_o;
   logic                        res_flag_o;
   logic                        yumi_i;

   // items waiting to be offered on each lane
   join_pkg::join_op_e          a_op_src[$];
   logic [join_pkg::DATA_W-1:0] a_dat_src[$];
   logic [join_pkg::DATA_W-1:0] b_dat_src[$];

   // accepted but not yet matched by a result
   join_pkg::join_op_e          exp_op_q[$];
   logic [join_pkg::DATA_W-1:0] exp_a_q[$];
   logic [join_pkg::DATA_W-1:0] exp_b_q[$];

   // 0 idle, 1 every cycle, 2 random
   int a_mode = 0;
   int b_mode = 0;
   int y_mode = 0;

   logic [31:0] lcg_state = 32'h7f74_aa46;
   int cyc = 0;
   int n_results = 0;

   // streaming latency capture
   bit lat_arm = 1'b0;
   int a_first = -1;
   int b_first = -1;
   int res_first = -1;
   int res_last = -1;

   join_top u_dut (.*);

   initial
   begin
      clk_i = 1'b0;
      forever
      begin
         #50 clk_i = ~clk_i;
      end
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [join_pkg::DATA_W-1:0] rand16();
      logic [31:0] r;
      r = next_rand();
      return r[31:16];
   endfunction

   function automatic join_pkg::join_op_e rand_op();
      logic [31:0] r;
      r = next_rand();
      return join_pkg::join_op_e'(3'(r[31:16] % 16'd6));
   endfunction

   // mode 2 offers about three cycles in four
   function automatic bit lane_go(input int mode);
      logic [31:0] r;
      r = next_rand();
      return (mode == 1) || (mode == 2 && r[21:20] != 2'b00);
   endfunction

   // expected {flag, result} straight from the operation rules
   function automatic logic [join_pkg::RES_W-1:0] ref_result(
      input join_pkg::join_op_e          op,
      input logic [join_pkg::DATA_W-1:0] a,
      input logic [join_pkg::DATA_W-1:0] b
   );
      int sum;
      logic [join_pkg::RES_W-1:0] r;
      sum = int'(a) + int'(b);
      r = '0;
      case (op)
         join_pkg::OP_ADD: r = {sum >= (1 << join_pkg::DATA_W), sum[join_pkg::DATA_W-1:0]};
         join_pkg::OP_SUB: r = {a < b, a - b};
         join_pkg::OP_AND: r = {1'b0, a & b};
         join_pkg::OP_XOR: r = {1'b0, a ^ b};
         // ties keep a
         join_pkg::OP_MIN: r = (b < a) ? {1'b1, b} : {1'b0, a};
         join_pkg::OP_MAX: r = (b > a) ? {1'b1, b} : {1'b0, a};
         default: r = '0;
      endcase
      return r;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic expect_bit(input string name, input logic got, input logic want);
      assert (got === want)
      else stop_run($sformatf("FAIL %s got %h expected %h", name, got, want));
   endtask

   task automatic expect_word(input string name, input logic [join_pkg::DATA_W-1:0] got,
                              input logic [join_pkg::DATA_W-1:0] want);
      assert (got === want)
      else stop_run($sformatf("FAIL %s got %h expected %h", name, got, want));
   endtask

   task automatic push_pair(input join_pkg::join_op_e op, input logic [15:0] a,
                            input logic [15:0] b);
      a_op_src.push_back(op);
      a_dat_src.push_back(a);
      b_dat_src.push_back(b);
   endtask

   task automatic wait_ready_low(input bit need_a, input bit need_b, input int limit);
      int n;
      n = 0;
      @(negedge clk_i);
      while ((need_a && a_ready_o) || (need_b && b_ready_o))
      begin
         n++;
         if (n > limit)
            stop_run("timeout waiting for a lane FIFO to fill");
         else
            @(negedge clk_i);
      end
   endtask

   // everything offered, accepted and consumed
   task automatic wait_drained(input int limit, input string what);
      int n;
      n = 0;
      @(negedge clk_i);
      while (a_op_src.size() != 0 || b_dat_src.size() != 0 || a_v_i || b_v_i
             || exp_a_q.size() != 0 || exp_b_q.size() != 0 || res_v_o)
      begin
         n++;
         if (n > limit)
            stop_run({"timeout waiting for ", what, " to drain"});
         else
            @(negedge clk_i);
      end
   endtask

   task automatic check_result();
      logic [join_pkg::RES_W-1:0]  exp;
      join_pkg::join_op_e          op;
      logic [join_pkg::DATA_W-1:0] a;
      logic [join_pkg::DATA_W-1:0] b;
      assert (exp_a_q.size() > 0 && exp_b_q.size() > 0)
      else stop_run("result presented with no accepted operand pair");
      op = exp_op_q.pop_front();
      a = exp_a_q.pop_front();
      b = exp_b_q.pop_front();
      exp = ref_result(op, a, b);
      expect_word("res_data_o", res_data_o, exp[join_pkg::DATA_W-1:0]);
      expect_bit("res_flag_o", res_flag_o, exp[join_pkg::RES_W-1]);
      n_results++;
   endtask

   // scoreboard sees the pre-edge values
   always @(posedge clk_i)
   begin
      cyc = cyc + 1;
      if (!reset_i)
      begin
         if (a_v_i && a_ready_o)
         begin
            exp_op_q.push_back(a_op_i);
            exp_a_q.push_back(a_data_i);
            if (lat_arm && a_first < 0)
               a_first = cyc;
         end
         if (b_v_i && b_ready_o)
         begin
            exp_b_q.push_back(b_data_i);
            if (lat_arm && b_first < 0)
               b_first = cyc;
         end
         if (lat_arm && res_v_o && res_first < 0)
            res_first = cyc;
         if (res_v_o && yumi_i)
         begin
            check_result();
            if (lat_arm)
               res_last = cyc;
         end
      end
   end

   // lane and consumer driver 5 ns after each edge
   initial
   begin
      logic a_acc;
      logic b_acc;
      a_v_i = 1'b0;
      a_op_i = join_pkg::OP_ADD;
      a_data_i = '0;
      b_v_i = 1'b0;
      b_data_i = '0;
      yumi_i = 1'b0;
      forever
      begin
         @(posedge clk_i);
         a_acc = a_v_i & a_ready_o;
         b_acc = b_v_i & b_ready_o;
         #5;
         // a pending item is held until taken
         if (!a_v_i || a_acc)
         begin
            a_v_i = 1'b0;
            if (a_op_src.size() > 0 && lane_go(a_mode))
            begin
               a_v_i = 1'b1;
               a_op_i = a_op_src.pop_front();
               a_data_i = a_dat_src.pop_front();
            end
         end
         if (!b_v_i || b_acc)
         begin
            b_v_i = 1'b0;
            if (b_dat_src.size() > 0 && lane_go(b_mode))
            begin
               b_v_i = 1'b1;
               b_data_i = b_dat_src.pop_front();
            end
         end
         yumi_i = res_v_o & lane_go(y_mode);
      end
   end

   initial
   begin
      int later;
      logic [join_pkg::RES_W-1:0] held;
      reset_i = 1'b1;
      repeat (3) @(posedge clk_i);
      #5 reset_i = 1'b0;
      @(negedge clk_i);

      expect_bit("a_ready_o", a_ready_o, 1'b1);
      expect_bit("b_ready_o", b_ready_o, 1'b1);
      expect_bit("res_v_o", res_v_o, 1'b0);

      // opcode sweep with carry, borrow and ties first
      push_pair(join_pkg::OP_ADD, 16'hffff, 16'h0001);
      push_pair(join_pkg::OP_ADD, 16'h8000, 16'h8000);
      push_pair(join_pkg::OP_ADD, 16'h1234, 16'h0111);
      push_pair(join_pkg::OP_SUB, 16'h0001, 16'h0002);
      push_pair(join_pkg::OP_SUB, 16'h5555, 16'h5555);
      push_pair(join_pkg::OP_SUB, 16'h0000, 16'hffff);
      push_pair(join_pkg::OP_AND, 16'hf0f0, 16'hff00);
      push_pair(join_pkg::OP_XOR, 16'ha5a5, 16'h5a5a);
      push_pair(join_pkg::OP_MIN, 16'h0007, 16'h0007);
      push_pair(join_pkg::OP_MIN, 16'h0009, 16'h0003);
      push_pair(join_pkg::OP_MIN, 16'h0002, 16'hffff);
      push_pair(join_pkg::OP_MAX, 16'h4444, 16'h4444);
      push_pair(join_pkg::OP_MAX, 16'h0001, 16'h8000);
      push_pair(join_pkg::OP_MAX, 16'hffff, 16'h0000);
      for (int i = 0; i < 24; i++)
         push_pair(join_pkg::join_op_e'(3'(i % 6)), rand16(), rand16());
      a_mode = 1;
      b_mode = 1;
      y_mode = 1;
      wait_drained(300, "opcode sweep");

      // lane A runs ahead until its FIFO fills
      b_mode = 0;
      for (int i = 0; i < 6; i++)
         push_pair(rand_op(), rand16(), rand16());
      wait_ready_low(1'b1, 1'b0, 20);
      expect_bit("b_ready_o", b_ready_o, 1'b1);
      expect_bit("res_v_o", res_v_o, 1'b0);
      b_mode = 1;
      y_mode = 2;
      wait_drained(200, "uneven lanes");

      // consumer stalls and the whole stage backs up
      y_mode = 0;
      for (int i = 0; i < 8; i++)
         push_pair(rand_op(), rand16(), rand16());
      wait_ready_low(1'b1, 1'b1, 50);
      expect_bit("res_v_o", res_v_o, 1'b1);
      // oldest accepted pair is the one waiting at the output
      held = ref_result(exp_op_q[0], exp_a_q[0], exp_b_q[0]);
      expect_word("res_data_o", res_data_o, held[join_pkg::DATA_W-1:0]);
      expect_bit("res_flag_o", res_flag_o, held[join_pkg::RES_W-1]);
      repeat (12) @(negedge clk_i);
      expect_word("res_data_o", res_data_o, held[join_pkg::DATA_W-1:0]);
      expect_bit("res_flag_o", res_flag_o, held[join_pkg::RES_W-1]);
      expect_bit("a_ready_o", a_ready_o, 1'b0);
      expect_bit("b_ready_o", b_ready_o, 1'b0);
      y_mode = 1;
      wait_drained(200, "back-pressure");

      // streaming with 2 cycle latency then one per cycle
      for (int i = 0; i < 20; i++)
         push_pair(rand_op(), rand16(), rand16());
      lat_arm = 1'b1;
      wait_drained(200, "streaming");
      lat_arm = 1'b0;
      later = (a_first > b_first) ? a_first : b_first;
      assert (res_first - later == 2)
      else stop_run($sformatf("first result came %0d cycles after the pair, not 2",
                              res_first - later));
      assert (res_last - res_first == 19)
      else stop_run("streaming results did not leave one per cycle");

      // mixed random traffic
      for (int i = 0; i < 2000; i++)
         push_pair(rand_op(), rand16(), rand16());
      a_mode = 2;
      b_mode = 2;
      y_mode = 2;
      wait_drained(20000, "random traffic");

      if (exp_op_q.size() == 0 && exp_a_q.size() == 0 && exp_b_q.size() == 0)
      begin
         $display("Regression passed");
         $finish;
      end
      else
         stop_run("operands left unmatched at the end of the run");
   end

endmodule

// File: bench/join_assertions.sv
/* protocol checks for join_top, attached with bind
   FIFO status flops are reached by hierarchical name */

`timescale 1ns/1ps

module join_assertions
(
   input logic                        clk_i,
   input logic                        reset_i,
   input logic                        a_yumi_i,
   input logic                        b_yumi_i,
   input logic                        a_v_i,
   input logic                        b_v_i,
   input logic                        res_v_i,
   input logic                        res_yumi_i,
   input logic [join_pkg::DATA_W-1:0] res_data_i,
   input logic                        res_flag_i,
   input logic                        a_full_i,
   input logic                        a_empty_i,
   input logic                        b_full_i,
   input logic                        b_empty_i,
   input logic                        res_full_i,
   input logic                        res_empty_i
);

   // both lanes always leave together
   assert property (@(posedge clk_i) disable iff (reset_i) a_yumi_i == b_yumi_i)
      else $error("lane yumis differ");

   // no dequeue from an empty FIFO
   assert property (@(posedge clk_i) disable iff (reset_i) a_yumi_i |-> a_v_i)
      else $error("yumi on empty lane A FIFO");
   assert property (@(posedge clk_i) disable iff (reset_i) b_yumi_i |-> b_v_i)
      else $error("yumi on empty lane B FIFO");
   assert property (@(posedge clk_i) disable iff (reset_i) res_yumi_i |-> res_v_i)
      else $error("yumi on empty output FIFO");

   // status flags are exclusive
   assert property (@(posedge clk_i) disable iff (reset_i)
                    !(a_full_i && a_empty_i) && !(b_full_i && b_empty_i)
                    && !(res_full_i && res_empty_i))
      else $error("FIFO full and empty at once");

   // head holds while the consumer waits
   assert property (@(posedge clk_i) disable iff (reset_i)
                    (res_v_i && !res_yumi_i) |=> ($stable(res_data_i) && $stable(res_flag_i)))
      else $error("result changed while stalled");

endmodule

bind join_top join_assertions u_assert
(
   .clk_i       (clk_i),
   .reset_i     (reset_i),
   .a_yumi_i    (lane_a_yumi),
   .b_yumi_i    (lane_b_yumi),
   .a_v_i       (lane_a_v),
   .b_v_i       (lane_b_v),
   .res_v_i     (res_v_o),
   .res_yumi_i  (yumi_i),
   .res_data_i  (res_data_o),
   .res_flag_i  (res_flag_o),
   .a_full_i    (u_lane_a.full_r),
   .a_empty_i   (u_lane_a.empty_r),
   .b_full_i    (u_lane_b.full_r),
   .b_empty_i   (u_lane_b.empty_r),
   .res_full_i  (u_res.full_r),
   .res_empty_i (u_res.empty_r)
);

// File: hw/join_top.sv
/* two-lane join stage: lane FIFOs, combinational join, output FIFO
   inputs are strict ready/valid; raise yumi_i only while res_v_o is high
   latency from the later accepted operand to res_v_o is 2 cycles */

`timescale 1ns/1ps

module join_top
(
   input  logic                        clk_i,
   input  logic                        reset_i,

   // lane A, opcode plus operand
   input  logic                        a_v_i,
   input  join_pkg::join_op_e          a_op_i,
   input  logic [join_pkg::DATA_W-1:0] a_data_i,
   output logic                        a_ready_o,

   // lane B, operand
   input  logic                        b_v_i,
   input  logic [join_pkg::DATA_W-1:0] b_data_i,
   output logic                        b_ready_o,

   // result, valid/yumi
   output logic                        res_v_o,
   output logic [join_pkg::DATA_W-1:0] res_data_o,
   output logic                        res_flag_o,
   input  logic                        yumi_i
);

   // lane A packing and FIFO head
   logic [join_pkg::LANE_A_W-1:0] lane_a_in;
   logic                          lane_a_v;
   logic [join_pkg::LANE_A_W-1:0] lane_a_data;
   logic                          lane_a_yumi;

   // lane B FIFO head
   logic                          lane_b_v;
   logic [join_pkg::LANE_B_W-1:0] lane_b_data;
   logic                          lane_b_yumi;

   // join to output FIFO
   logic                          res_in_v;
   logic [join_pkg::RES_W-1:0]    res_in_data;
   logic                          res_in_ready;

   // output FIFO head
   logic [join_pkg::RES_W-1:0]    res_out_data;

   // opcode goes in the top bits
   assign lane_a_in = {a_op_i, a_data_i};

   two_fifo #(.width_p(join_pkg::LANE_A_W)) u_lane_a
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .ready_o (a_ready_o),
      .v_i     (a_v_i),
      .data_i  (lane_a_in),
      .v_o     (lane_a_v),
      .data_o  (lane_a_data),
      .yumi_i  (lane_a_yumi)
   );

   two_fifo #(.width_p(join_pkg::LANE_B_W)) u_lane_b
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .ready_o (b_ready_o),
      .v_i     (b_v_i),
      .data_i  (b_data_i),
      .v_o     (lane_b_v),
      .data_o  (lane_b_data),
      .yumi_i  (lane_b_yumi)
   );

   operand_join u_join
   (
      .a_v_i       (lane_a_v),
      .a_data_i    (lane_a_data),
      .a_yumi_o    (lane_a_yumi),
      .b_v_i       (lane_b_v),
      .b_data_i    (lane_b_data),
      .b_yumi_o    (lane_b_yumi),
      .out_ready_i (res_in_ready),
      .out_v_o     (res_in_v),
      .out_data_o  (res_in_data)
   );

   two_fifo #(.width_p(join_pkg::RES_W)) u_res
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .ready_o (res_in_ready),
      .v_i     (res_in_v),
      .data_i  (res_in_data),
      .v_o     (res_v_o),
      .data_o  (res_out_data),
      .yumi_i  (yumi_i)
   );

   // flag sits in the top bit of the result word
   assign res_flag_o = res_out_data[join_pkg::RES_W-1];
   assign res_data_o = res_out_data[join_pkg::DATA_W-1:0];

endmodule

// File: hw/operand_join.sv
/* combinational join of the two lane FIFO heads into one result word
   both lanes are consumed together, only when the output FIFO has room
   unused opcodes produce zero with a clear flag */

`timescale 1ns/1ps

module operand_join
(
   // lane A head, opcode and operand
   input  logic                          a_v_i,
   input  logic [join_pkg::LANE_A_W-1:0] a_data_i,
   output logic                          a_yumi_o,

   // lane B head, operand only
   input  logic                          b_v_i,
   input  logic [join_pkg::LANE_B_W-1:0] b_data_i,
   output logic                          b_yumi_o,

   // output FIFO enqueue side
   input  logic                          out_ready_i,
   output logic                          out_v_o,
   output logic [join_pkg::RES_W-1:0]    out_data_o
);

   // single fire condition for the whole stage
   logic fire;

   // unpacked head fields
   join_pkg::join_op_e              op;
   logic [join_pkg::DATA_W-1:0]     opa;
   logic [join_pkg::DATA_W-1:0]     opb;

   // wide arithmetic, top bit is carry or borrow
   logic [join_pkg::DATA_W:0]       sum;
   logic [join_pkg::DATA_W:0]       diff;

   // unsigned compares for min and max
   logic                            b_lt_a;
   logic                            a_lt_b;

   // computed result
   logic [join_pkg::DATA_W-1:0]     result;
   logic                            flag;

   // pair only when both heads are there and the output can take it
   assign fire = a_v_i & b_v_i & out_ready_i;

   assign a_yumi_o = fire;
   assign b_yumi_o = fire;
   assign out_v_o  = fire;

   // lane A word has the opcode on top
   assign op  = join_pkg::join_op_e'(a_data_i[join_pkg::LANE_A_W-1 -: join_pkg::OP_W]);
   assign opa = a_data_i[join_pkg::DATA_W-1:0];
   assign opb = b_data_i;

   assign sum  = {1'b0, opa} + {1'b0, opb};
   // borrow lands in the top bit exactly when a < b
   assign diff = {1'b0, opa} - {1'b0, opb};

   assign b_lt_a = (opb < opa);
   assign a_lt_b = (opa < opb);

   always_comb
   begin
      result = '0;
      flag   = 1'b0;
      case (op)
         join_pkg::OP_ADD:
         begin
            result = sum[join_pkg::DATA_W-1:0];
            flag   = sum[join_pkg::DATA_W];
         end
         join_pkg::OP_SUB:
         begin
            result = diff[join_pkg::DATA_W-1:0];
            flag   = diff[join_pkg::DATA_W];
         end
         join_pkg::OP_AND:
         begin
            result = opa & opb;
         end
         join_pkg::OP_XOR:
         begin
            result = opa ^ opb;
         end
         join_pkg::OP_MIN:
         begin
            // b only when strictly smaller, ties keep a
            result = b_lt_a ? opb : opa;
            flag   = b_lt_a;
         end
         join_pkg::OP_MAX:
         begin
            // b only when strictly larger
            result = a_lt_b ? opb : opa;
            flag   = a_lt_b;
         end
         default:
         begin
            result = '0;
            flag   = 1'b0;
         end
      endcase
   end

   // flag on top of the result
   assign out_data_o = {flag, result};

endmodule

// File: hw/two_fifo.sv
/* two-entry FIFO, ready/valid on the input and valid/yumi on the output
   yumi_i must only be raised while v_o is high; no enqueue while full
   ready_o and v_o come straight from flops */

`timescale 1ns/1ps

module two_fifo
#(
   parameter int width_p = 8
)
(
   input  logic               clk_i,
   input  logic               reset_i,

   // input side
   output logic               ready_o,
   input  logic               v_i,
   input  logic [width_p-1:0] data_i,

   // output side
   output logic               v_o,
   output logic [width_p-1:0] data_o,
   input  logic               yumi_i
);

   // storage, no reset on the payload
   logic [width_p-1:0] mem_r [2];

   // one-bit pointers, a toggle advances them
   logic head_r;
   logic tail_r;

   // registered status
   logic empty_r;
   logic full_r;

   // handshakes
   logic enq;
   logic deq;

   // transfer only when not full, so a valid held on full is ignored
   assign enq = v_i & ~full_r;

   // consumer takes the head on yumi
   assign deq = yumi_i;

   assign ready_o = ~full_r;
   assign v_o     = ~empty_r;

   // head word drives the output directly
   assign data_o = mem_r[head_r];

   // write port
   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         mem_r[tail_r] <= data_i;
      end
   end

   // pointers
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         head_r <= 1'b0;
         tail_r <= 1'b0;
      end
      else
      begin
         if (enq)
         begin
            tail_r <= ~tail_r;
         end
         if (deq)
         begin
            head_r <= ~head_r;
         end
      end
   end

   // status flags
   // with only two entries the next-state terms reduce to a few gates
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         empty_r <= 1'b1;
         full_r  <= 1'b0;
      end
      else
      begin
         // stays empty with no enqueue, or drops to empty when the
         // single entry leaves and nothing arrives
         empty_r <= (empty_r & ~enq)
                  | (~full_r & deq & ~enq);

         // fills from one entry on enqueue alone, holds while no dequeue
         full_r  <= (~empty_r & enq & ~deq)
                  | (full_r & ~deq);
      end
   end

endmodule

// File: hw/join_pkg.sv
/* shared widths and opcodes for the two-lane join stage
   opcodes 6 and 7 are unused and give a zero result with a zero flag */

package join_pkg;

   // operand and result width
   localparam int DATA_W = 16;

   // opcode field width
   localparam int OP_W = 3;

   // lane A word, opcode in the top bits, operand below
   localparam int LANE_A_W = OP_W + DATA_W;

   // lane B word is just the operand
   localparam int LANE_B_W = DATA_W;

   // output word, flag in the top bit, result below
   localparam int RES_W = 1 + DATA_W;

   // join operations
   // add:      flag is the carry out
   // sub:      a minus b, flag is the borrow (a < b unsigned)
   // and, xor: flag always zero
   // min, max: unsigned compare, flag set when b was picked
   //           ties pick a
   typedef enum logic [OP_W-1:0]
   {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_XOR = 3'd3,
      OP_MIN = 3'd4,
      OP_MAX = 3'd5
   } join_op_e;

endpackage
